// File: source/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

	typedef logic [15:0] instruction_t;  // one instruction word
	typedef logic [3:0] alu_op_t;        // bits 7:4 of arithmetic format
	typedef logic [2:0] cond_t;          // bits 10:8 of conditional branch

	// major opcode in bits 15:14
	localparam logic [1:0] OP_LOAD = 2'd0;
	localparam logic [1:0] OP_STORE = 2'd1;
	localparam logic [1:0] OP_IMM = 2'd2;    // LI and branches
	localparam logic [1:0] OP_ARITH = 2'd3;

	// bits 13:11 under OP_IMM
	localparam logic [2:0] OP2_LI = 3'd0;
	localparam logic [2:0] OP2_B = 3'd4;
	localparam logic [2:0] OP2_BCOND = 3'd7;

	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR = 4'd3;
	localparam alu_op_t ALU_XOR = 4'd4;
	localparam alu_op_t ALU_CMP = 4'd5;   // SUB without write
	localparam alu_op_t ALU_MOV = 4'd6;
	localparam alu_op_t ALU_SLL = 4'd8;
	localparam alu_op_t ALU_SRL = 4'd10;
	localparam alu_op_t ALU_IN = 4'd12;
	localparam alu_op_t ALU_OUT = 4'd13;
	localparam alu_op_t ALU_NOP = 4'd14;
	localparam alu_op_t ALU_HLT = 4'd15;

	localparam cond_t COND_BE = 3'd0;
	localparam cond_t COND_BLT = 3'd1;
	localparam cond_t COND_BLE = 3'd2;
	localparam cond_t COND_BNE = 3'd3;

	localparam instruction_t NOP_INSTRUCTION = {OP_ARITH, 6'd0, ALU_NOP, 4'd0};

endpackage

`default_nettype wire

// File: source/cpu_machine_pkg.sv
`default_nettype none

package cpu_machine_pkg;

	typedef logic [15:0] word_t;      // data word and PC
	typedef logic [2:0] reg_index_t;  // r0..r7
	typedef logic [3:0] flags_t;      // S Z C V

	// flag bit positions in flags_t
	localparam int FLAG_S = 3;  // sign of result
	localparam int FLAG_Z = 2;  // result zero
	localparam int FLAG_C = 1;  // carry or borrow
	localparam int FLAG_V = 0;  // signed overflow

endpackage

`default_nettype wire

// File: source/fetch_link_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_link_if;
	import cpu_isa_pkg::*;
	import cpu_machine_pkg::*;

	instruction_t instruction;  // fetch/decode register
	word_t next_pc;             // fetched address plus one
	logic hold;                 // stall or halted
	logic redirect;             // taken branch strobe
	word_t redirect_target;

	modport fetch (
		output instruction, next_pc,
		input hold, redirect, redirect_target
	);

	modport decode (
		input instruction, next_pc,
		output hold, redirect, redirect_target
	);

endinterface

`default_nettype wire

// File: source/memory_link_if.sv
`timescale 1ns/1ps
`default_nettype none

interface memory_link_if;
	import cpu_machine_pkg::*;

	word_t result;             // ALU result, address or LI value
	word_t store_data;
	logic read_en;             // LD
	logic write_en;            // ST
	logic reg_write;
	reg_index_t write_index;
	logic take_input;          // IN

	modport execute (
		output result, store_data, read_en, write_en,
		output reg_write, write_index, take_input
	);

	modport memory (
		input result, store_data, read_en, write_en,
		input reg_write, write_index, take_input
	);

endinterface

`default_nettype wire

// File: source/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
	parameter int ADDRESS_WIDTH = 8
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic prog_write,
	input wire logic [ADDRESS_WIDTH-1:0] prog_address,
	input wire cpu_isa_pkg::instruction_t prog_data,
	fetch_link_if.fetch link
);
	import cpu_isa_pkg::*;
	import cpu_machine_pkg::*;

	instruction_t memory [2**ADDRESS_WIDTH];  // instruction array
	word_t pc;                                 // next address to fetch
	word_t fetch_address;
	word_t fetch_plus_one;

	// program port, also works with reset held low
	always_ff @(posedge clock) begin
		if (prog_write)
			memory[prog_address] <= prog_data;
	end

	// branch target fetched in the redirect cycle itself
	assign fetch_address = link.redirect ? link.redirect_target : pc;
	assign fetch_plus_one = fetch_address + 16'd1;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= '0;
			link.instruction <= NOP_INSTRUCTION;
			link.next_pc <= '0;
		end else if (link.redirect || !link.hold) begin
			pc <= fetch_plus_one;
			link.instruction <= memory[fetch_address[ADDRESS_WIDTH-1:0]];  // low bits only
			link.next_pc <= fetch_plus_one;
		end
	end

endmodule

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input wire logic clock,
	input wire logic reset,
	input wire cpu_machine_pkg::reg_index_t read_index_a,
	input wire cpu_machine_pkg::reg_index_t read_index_b,
	output cpu_machine_pkg::word_t read_data_a,
	output cpu_machine_pkg::word_t read_data_b,
	input wire logic write_enable,
	input wire cpu_machine_pkg::reg_index_t write_index,
	input wire cpu_machine_pkg::word_t write_data
);
	import cpu_machine_pkg::*;

	word_t registers [8];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 8; i++)
				registers[i] <= '0;
		end else if (write_enable) begin
			registers[write_index] <= write_data;
		end
	end

	// write-through so decode sees the write-back value this cycle
	assign read_data_a = (write_enable && write_index == read_index_a) ? write_data :
		registers[read_index_a];
	assign read_data_b = (write_enable && write_index == read_index_b) ? write_data :
		registers[read_index_b];

endmodule

`default_nettype wire

// File: source/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
	input wire logic clock,
	input wire logic reset,
	fetch_link_if.decode link,
	input wire cpu_machine_pkg::flags_t flags_now,
	input wire logic wb_enable,
	input wire cpu_machine_pkg::reg_index_t wb_index,
	input wire cpu_machine_pkg::word_t wb_data,
	output logic halted,
	output cpu_isa_pkg::alu_op_t alu_op,
	output cpu_machine_pkg::word_t operand_a,
	output cpu_machine_pkg::word_t operand_b,
	output cpu_machine_pkg::word_t immediate,
	output logic [3:0] shift,
	output cpu_machine_pkg::reg_index_t source_index,
	output cpu_machine_pkg::reg_index_t dest_index,
	output logic use_immediate,
	output logic load_immediate,
	output logic is_alu,
	output logic sets_flags,
	output logic reads_memory,
	output logic writes_memory,
	output logic reg_write,
	output logic take_input,
	output logic output_en
);
	import cpu_isa_pkg::*;
	import cpu_machine_pkg::*;

	typedef enum logic {state_running, state_halted} run_state_t;

	run_state_t run_state;
	instruction_t instruction;
	alu_op_t func;                // bits 7:4
	cond_t cond;                  // bits 10:8
	reg_index_t index_a;          // ALU y side, or base for LD/ST
	reg_index_t index_b;          // ALU x side and write destination
	word_t read_a;
	word_t read_b;
	word_t ext_d;                 // sign-extended d
	logic is_arith, is_load, is_store, is_li;
	logic is_jump, is_cond, is_hlt, is_in, is_out;
	logic is_calc;                // ALU op that sets flags
	logic uses_a, uses_b;
	logic stall, flush, bubble;
	logic cond_true, taken;

	assign instruction = link.instruction;
	assign func = instruction[7:4];
	assign cond = instruction[10:8];
	assign is_arith = instruction[15:14] == OP_ARITH;
	assign is_load = instruction[15:14] == OP_LOAD;
	assign is_store = instruction[15:14] == OP_STORE;
	assign is_li = instruction[15:11] == {OP_IMM, OP2_LI};
	assign is_jump = instruction[15:11] == {OP_IMM, OP2_B};
	assign is_cond = instruction[15:11] == {OP_IMM, OP2_BCOND};
	assign is_hlt = is_arith && func == ALU_HLT;
	assign is_in = is_arith && func == ALU_IN;
	assign is_out = is_arith && func == ALU_OUT;
	assign is_calc = is_arith && (func <= ALU_MOV || func == ALU_SLL || func == ALU_SRL);

	// LD/ST swap fields so port a carries the base, port b the rs register
	assign index_a = (is_load || is_store) ? instruction[10:8] : instruction[13:11];
	assign index_b = (is_load || is_store) ? instruction[13:11] : instruction[10:8];
	assign ext_d = {{8{instruction[7]}}, instruction[7:0]};

	register_file register_file_i (
		.clock(clock),
		.reset(reset),
		.read_index_a(index_a),
		.read_index_b(index_b),
		.read_data_a(read_a),
		.read_data_b(read_b),
		.write_enable(wb_enable),
		.write_index(wb_index),
		.write_data(wb_data)
	);

	assign uses_a = is_load || is_store || (is_arith && (func <= ALU_MOV || func == ALU_OUT));
	assign uses_b = is_store ||
		(is_arith && (func <= ALU_CMP || func == ALU_SLL || func == ALU_SRL));

	// LD and IN values appear only after the memory stage
	assign stall = (reads_memory || take_input) &&
		((uses_a && index_a == dest_index) || (uses_b && index_b == dest_index));
	assign flush = link.redirect;  // slot after taken branch
	assign halted = run_state == state_halted;
	assign bubble = stall || flush || halted;
	assign link.hold = (stall && !flush) || halted;

	always_comb begin
		case (cond)
			COND_BE: cond_true = flags_now[FLAG_Z];
			COND_BLT: cond_true = flags_now[FLAG_S] ^ flags_now[FLAG_V];
			COND_BLE: cond_true = flags_now[FLAG_Z] | (flags_now[FLAG_S] ^ flags_now[FLAG_V]);
			COND_BNE: cond_true = !flags_now[FLAG_Z];
			default: cond_true = 1'b0;
		endcase
	end

	assign taken = (is_jump || (is_cond && cond_true)) && !bubble;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			run_state <= state_running;
			link.redirect <= 1'b0;
		end else begin
			if (is_hlt && !bubble)
				run_state <= state_halted;  // stays until reset
			link.redirect <= taken;
		end
	end

	always_ff @(posedge clock) begin
		link.redirect_target <= link.next_pc + ext_d;  // own address + 1 + d
	end

	// decode/execute control, all low for a bubble
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			use_immediate <= 1'b0;
			load_immediate <= 1'b0;
			is_alu <= 1'b0;
			sets_flags <= 1'b0;
			reads_memory <= 1'b0;
			writes_memory <= 1'b0;
			reg_write <= 1'b0;
			take_input <= 1'b0;
			output_en <= 1'b0;
		end else begin
			use_immediate <= !bubble && (is_load || is_store);
			load_immediate <= !bubble && is_li;
			is_alu <= !bubble && is_arith;
			sets_flags <= !bubble && is_calc;
			reads_memory <= !bubble && is_load;
			writes_memory <= !bubble && is_store;
			reg_write <= !bubble && (is_load || is_li || is_in || (is_calc && func != ALU_CMP));
			take_input <= !bubble && is_in;
			output_en <= !bubble && is_out;
		end
	end

	always_ff @(posedge clock) begin
		alu_op <= func;
		operand_a <= read_a;
		operand_b <= read_b;
		immediate <= ext_d;
		shift <= instruction[3:0];
		source_index <= index_a;
		dest_index <= index_b;
	end

endmodule

`default_nettype wire

// File: source/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input wire logic clock,
	input wire logic reset,
	input wire cpu_isa_pkg::alu_op_t alu_op,
	input wire cpu_machine_pkg::word_t operand_a,
	input wire cpu_machine_pkg::word_t operand_b,
	input wire cpu_machine_pkg::word_t immediate,
	input wire logic [3:0] shift,
	input wire cpu_machine_pkg::reg_index_t source_index,
	input wire cpu_machine_pkg::reg_index_t dest_index,
	input wire logic use_immediate,
	input wire logic load_immediate,
	input wire logic is_alu,
	input wire logic sets_flags,
	input wire logic reads_memory,
	input wire logic writes_memory,
	input wire logic reg_write,
	input wire logic take_input,
	input wire logic output_en,
	input wire logic wb_enable,
	input wire cpu_machine_pkg::reg_index_t wb_index,
	input wire cpu_machine_pkg::word_t wb_data,
	output cpu_machine_pkg::flags_t flags_now,
	output cpu_machine_pkg::word_t out,
	output logic out_valid,
	memory_link_if.execute link
);
	import cpu_isa_pkg::*;
	import cpu_machine_pkg::*;

	word_t forward_a;       // r[rs], or LD/ST base
	word_t forward_b;       // r[rd], or ST data
	word_t alu_x;
	word_t alu_y;
	word_t alu_result;
	logic [16:0] sum;       // carry in bit 16
	logic [16:0] difference;  // borrow in bit 16
	logic carry;
	logic overflow;
	flags_t alu_flags;
	flags_t flag_register;

	// execute/memory result first, then write-back
	assign forward_a = (link.reg_write && link.write_index == source_index) ? link.result :
		(wb_enable && wb_index == source_index) ? wb_data : operand_a;
	assign forward_b = (link.reg_write && link.write_index == dest_index) ? link.result :
		(wb_enable && wb_index == dest_index) ? wb_data : operand_b;

	assign alu_x = use_immediate ? forward_a : forward_b;  // base + d for LD/ST
	assign alu_y = use_immediate ? immediate : forward_a;
	assign sum = {1'b0, alu_x} + {1'b0, alu_y};
	assign difference = {1'b0, alu_x} - {1'b0, alu_y};

	always_comb begin
		alu_result = sum[15:0];  // address when not arithmetic format
		carry = 1'b0;
		overflow = 1'b0;
		if (is_alu) begin
			case (alu_op)
				ALU_ADD: begin
					carry = sum[16];
					overflow = (alu_x[15] == alu_y[15]) && (sum[15] != alu_x[15]);
				end
				ALU_SUB, ALU_CMP: begin
					alu_result = difference[15:0];
					carry = difference[16];
					overflow = (alu_x[15] != alu_y[15]) && (difference[15] != alu_x[15]);
				end
				ALU_AND: alu_result = alu_x & alu_y;
				ALU_OR: alu_result = alu_x | alu_y;
				ALU_XOR: alu_result = alu_x ^ alu_y;
				ALU_MOV: alu_result = alu_y;
				ALU_SLL: alu_result = alu_x << shift;
				ALU_SRL: alu_result = alu_x >> shift;
				default: alu_result = alu_x;  // IN OUT NOP HLT write nothing
			endcase
		end
	end

	assign alu_flags[FLAG_S] = alu_result[15];
	assign alu_flags[FLAG_Z] = alu_result == '0;
	assign alu_flags[FLAG_C] = carry;
	assign alu_flags[FLAG_V] = overflow;

	// a branch in decode sees the flags of the instruction ahead of it
	assign flags_now = sets_flags ? alu_flags : flag_register;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			link.read_en <= 1'b0;
			link.write_en <= 1'b0;
			link.reg_write <= 1'b0;
			link.take_input <= 1'b0;
			flag_register <= '0;
			out <= '0;
			out_valid <= 1'b0;
		end else begin
			link.read_en <= reads_memory;
			link.write_en <= writes_memory;
			link.reg_write <= reg_write;
			link.take_input <= take_input;
			if (sets_flags)
				flag_register <= alu_flags;
			if (output_en)
				out <= forward_a;  // held until next OUT
			out_valid <= output_en;
		end
	end

	always_ff @(posedge clock) begin
		link.result <= load_immediate ? immediate : alu_result;
		link.store_data <= forward_b;
		link.write_index <= dest_index;
	end

endmodule

`default_nettype wire

// File: source/memory_unit.sv
`timescale 1ns/1ps
`default_nettype none

module memory_unit #(
	parameter int ADDRESS_WIDTH = 8
) (
	input wire logic clock,
	input wire logic reset,
	input wire cpu_machine_pkg::word_t in,
	memory_link_if.memory link,
	output logic wb_enable,
	output cpu_machine_pkg::reg_index_t wb_index,
	output cpu_machine_pkg::word_t wb_data
);
	import cpu_machine_pkg::*;

	word_t memory [2**ADDRESS_WIDTH];  // data array
	logic [ADDRESS_WIDTH-1:0] address;
	word_t read_data;
	word_t loaded;     // memory word or input port
	word_t result;
	logic use_loaded;

	assign address = link.result[ADDRESS_WIDTH-1:0];  // low bits only
	assign read_data = memory[address];

	always_ff @(posedge clock) begin
		if (link.write_en)
			memory[address] <= link.store_data;
	end

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb_enable <= 1'b0;
			use_loaded <= 1'b0;
		end else begin
			wb_enable <= link.reg_write;
			use_loaded <= link.read_en || link.take_input;
		end
	end

	always_ff @(posedge clock) begin
		loaded <= link.take_input ? in : read_data;
		result <= link.result;
		wb_index <= link.write_index;
	end

	assign wb_data = use_loaded ? loaded : result;  // write-back mux

endmodule

`default_nettype wire

// File: source/simple_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module simple_cpu #(
	parameter int ADDRESS_WIDTH = 8
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic prog_write,
	input wire logic [ADDRESS_WIDTH-1:0] prog_address,
	input wire cpu_isa_pkg::instruction_t prog_data,
	input wire cpu_machine_pkg::word_t in,
	output cpu_machine_pkg::word_t out,
	output logic out_valid,
	output logic halted
);
	import cpu_isa_pkg::*;
	import cpu_machine_pkg::*;

	alu_op_t alu_op;
	word_t operand_a;
	word_t operand_b;
	word_t immediate;
	logic [3:0] shift;
	reg_index_t source_index;
	reg_index_t dest_index;
	logic use_immediate, load_immediate, is_alu, sets_flags;       // decode/execute controls
	logic reads_memory, writes_memory, reg_write, take_input, output_en;
	flags_t flags_now;   // back from execute for branches
	logic wb_enable;
	reg_index_t wb_index;
	word_t wb_data;

	fetch_link_if fetch_link ();
	memory_link_if memory_link ();

	fetch_unit #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) fetch_unit_i (
		.clock(clock), .reset(reset),
		.prog_write(prog_write), .prog_address(prog_address), .prog_data(prog_data),
		.link(fetch_link.fetch)
	);

	decode_unit decode_unit_i (
		.clock(clock), .reset(reset),
		.link(fetch_link.decode),
		.flags_now(flags_now),
		.wb_enable(wb_enable), .wb_index(wb_index), .wb_data(wb_data),
		.halted(halted),
		.alu_op(alu_op), .operand_a(operand_a), .operand_b(operand_b),
		.immediate(immediate), .shift(shift),
		.source_index(source_index), .dest_index(dest_index),
		.use_immediate(use_immediate), .load_immediate(load_immediate),
		.is_alu(is_alu), .sets_flags(sets_flags),
		.reads_memory(reads_memory), .writes_memory(writes_memory),
		.reg_write(reg_write), .take_input(take_input), .output_en(output_en)
	);

	execute_unit execute_unit_i (
		.clock(clock), .reset(reset),
		.alu_op(alu_op), .operand_a(operand_a), .operand_b(operand_b),
		.immediate(immediate), .shift(shift),
		.source_index(source_index), .dest_index(dest_index),
		.use_immediate(use_immediate), .load_immediate(load_immediate),
		.is_alu(is_alu), .sets_flags(sets_flags),
		.reads_memory(reads_memory), .writes_memory(writes_memory),
		.reg_write(reg_write), .take_input(take_input), .output_en(output_en),
		.wb_enable(wb_enable), .wb_index(wb_index), .wb_data(wb_data),
		.flags_now(flags_now),
		.out(out), .out_valid(out_valid),
		.link(memory_link.execute)
	);

	memory_unit #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) memory_unit_i (
		.clock(clock), .reset(reset),
		.in(in),
		.link(memory_link.memory),
		.wb_enable(wb_enable), .wb_index(wb_index), .wb_data(wb_data)
	);

endmodule

`default_nettype wire

// File: sim/cpu_programs.svh
`ifndef CPU_PROGRAMS_SVH
`define CPU_PROGRAMS_SVH

localparam int ROW_COUNT = 6;
localparam int RANDOM_ROW = 5;     // in value and result drawn at run time
localparam int MAX_OUTPUTS = 3;
localparam instruction_t HALT = {OP_ARITH, 6'd0, ALU_HLT, 4'd0};

instruction_t program_table [ROW_COUNT][16];  // padded with HLT
word_t input_table [ROW_COUNT];
int expect_count [ROW_COUNT];                  // out_valid pulses per program
word_t expect_table [ROW_COUNT][MAX_OUTPUTS];

function automatic instruction_t arith(input alu_op_t op, input int rd, input int rs,
		input int sh);
	return {OP_ARITH, rs[2:0], rd[2:0], op, sh[3:0]};  // r[rd] <- r[rd] op r[rs]
endfunction

function automatic instruction_t li(input int rd, input int d);
	return {OP_IMM, OP2_LI, rd[2:0], d[7:0]};
endfunction

function automatic instruction_t ld(input int rs, input int rd, input int d);
	return {OP_LOAD, rs[2:0], rd[2:0], d[7:0]};  // r[rs] <- mem[r[rd]+d]
endfunction

function automatic instruction_t st(input int rs, input int rd, input int d);
	return {OP_STORE, rs[2:0], rd[2:0], d[7:0]};  // mem[r[rd]+d] <- r[rs]
endfunction

function automatic instruction_t jump(input int d);
	return {OP_IMM, OP2_B, 3'd0, d[7:0]};
endfunction

function automatic instruction_t branch(input cond_t c, input int d);
	return {OP_IMM, OP2_BCOND, c, d[7:0]};  // target is own address + 1 + d
endfunction

task automatic set_results(input int row, input int count, input word_t a, input word_t b,
		input word_t c);
	input_table[row] = 16'h0000;
	expect_count[row] = count;
	expect_table[row] = '{a, b, c};
endtask

task automatic fill_table();
	// 5 and 3, then add sub and or xor with both forward paths
	program_table[0] = '{li(1, 5), li(2, 3), arith(ALU_ADD, 1, 2, 0),
		arith(ALU_OUT, 0, 1, 0), arith(ALU_SUB, 1, 2, 0), li(3, 12),
		arith(ALU_AND, 3, 1, 0), arith(ALU_OUT, 0, 3, 0), arith(ALU_OR, 3, 2, 0),
		arith(ALU_XOR, 3, 1, 0), arith(ALU_OUT, 0, 3, 0), HALT, HALT,
		HALT, HALT, HALT};
	set_results(0, 3, 16'h0008, 16'h0004, 16'h0002);
	// mov and shifts of a negative LI value
	program_table[1] = '{li(4, -3), arith(ALU_MOV, 5, 4, 0), arith(ALU_SRL, 5, 0, 4),
		arith(ALU_OUT, 0, 5, 0), arith(ALU_SLL, 4, 0, 3), arith(ALU_OUT, 0, 4, 0),
		li(6, 127), arith(ALU_OUT, 0, 6, 0), HALT, HALT,
		HALT, HALT, HALT, HALT, HALT, HALT};
	set_results(1, 3, 16'h0FFF, 16'hFFE8, 16'h007F);
	// store/load round trips, each load used in the next slot
	program_table[2] = '{li(1, 85), li(2, 10), st(1, 2, 2), ld(3, 2, 2),
		arith(ALU_OUT, 0, 3, 0), ld(4, 2, 2), arith(ALU_ADD, 4, 3, 0),
		arith(ALU_OUT, 0, 4, 0), st(4, 2, -1), ld(5, 2, -1),
		arith(ALU_OUT, 0, 5, 0), HALT, HALT, HALT,
		HALT, HALT};
	set_results(2, 3, 16'h0055, 16'h00AA, 16'h00AA);
	// 2 - 5 is negative, BLT BLE BNE taken and BE not
	program_table[3] = '{li(1, 2), li(2, 5), arith(ALU_CMP, 1, 2, 0),
		branch(COND_BLT, 1), arith(ALU_OUT, 0, 1, 0), branch(COND_BE, 1),
		arith(ALU_OUT, 0, 1, 0), branch(COND_BLE, 1), arith(ALU_OUT, 0, 2, 0),
		branch(COND_BNE, 1), arith(ALU_OUT, 0, 2, 0), arith(ALU_OUT, 0, 2, 0),
		HALT, HALT, HALT, HALT};
	set_results(3, 2, 16'h0002, 16'h0005, 16'h0000);
	// 5 - 2 then 2 - 2, OUT after HLT at the end
	program_table[4] = '{li(1, 2), li(2, 5), arith(ALU_CMP, 2, 1, 0),
		branch(COND_BLT, 1), arith(ALU_OUT, 0, 1, 0), branch(COND_BLE, 1),
		arith(ALU_OUT, 0, 2, 0), arith(ALU_CMP, 1, 1, 0), branch(COND_BE, 1),
		arith(ALU_OUT, 0, 1, 0), branch(COND_BNE, 1), arith(ALU_OUT, 0, 2, 0),
		jump(1), arith(ALU_OUT, 0, 1, 0), HALT, arith(ALU_OUT, 0, 2, 0)};
	set_results(4, 3, 16'h0002, 16'h0005, 16'h0005);
	// in + in through the input stall
	program_table[5] = '{arith(ALU_IN, 1, 0, 0), arith(ALU_ADD, 1, 1, 0),
		arith(ALU_OUT, 0, 1, 0),
		HALT, HALT, HALT, HALT, HALT, HALT, HALT,
		HALT, HALT, HALT, HALT, HALT, HALT};
	set_results(5, 1, 16'h0000, 16'h0000, 16'h0000);
endtask

`endif

// File: sim/simple_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module simple_cpu_tb;
	import cpu_isa_pkg::*;
	import cpu_machine_pkg::*;

	localparam int ADDRESS_WIDTH = 8;
	localparam int HALT_TIMEOUT = 200;  // cycles per program
	localparam int DRAIN_CYCLES = 4;    // older instructions finish after halted

	logic clock;
	logic reset;
	logic prog_write;
	logic [ADDRESS_WIDTH-1:0] prog_address;
	instruction_t prog_data;
	word_t in;
	word_t out;
	logic out_valid;
	logic halted;

	word_t captured [$];       // out at every out_valid
	int checks;
	int errors;
	int timeouts;
	int unsigned random_state;

	`include "cpu_programs.svh"

	simple_cpu #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) simple_cpu_i (
		.clock(clock), .reset(reset),
		.prog_write(prog_write), .prog_address(prog_address), .prog_data(prog_data),
		.in(in), .out(out), .out_valid(out_valid), .halted(halted)
	);

	always #4 clock = ~clock;  // 8 ns period

	always @(negedge clock) begin
		if (reset === 1'b1 && out_valid === 1'b1)
			captured.push_back(out);
	end

	function automatic int unsigned next_random(input int unsigned state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// program port written while reset is held
	task automatic load_program(input int row);
		@(posedge clock);
		#1;
		reset = 1'b0;
		in = input_table[row];
		for (int i = 0; i < 16; i++) begin
			prog_write = 1'b1;
			prog_address = ADDRESS_WIDTH'(i);
			prog_data = program_table[row][i];
			@(posedge clock);
			#1;
		end
		prog_write = 1'b0;
		@(posedge clock);
		#1;
		captured.delete();
		reset = 1'b1;
	endtask

	task automatic check_outputs(input int row);
		int count;
		checks++;
		assert (captured.size() == expect_count[row]) else begin
			errors++;
			$display("** Error at %0t: row %0d out_valid pulses = %0d, expected %0d",
				$time, row, captured.size(), expect_count[row]);
		end
		count = (captured.size() < expect_count[row]) ? captured.size() : expect_count[row];
		for (int i = 0; i < count; i++) begin
			checks++;
			assert (captured[i] === expect_table[row][i]) else begin
				errors++;
				$display("** Error at %0t: row %0d out #%0d = %h, expected %h",
					$time, row, i, captured[i], expect_table[row][i]);
			end
		end
	endtask

	task automatic run_row(input int row);
		int cycles;
		load_program(row);
		@(negedge clock);
		checks += 2;
		assert (out_valid === 1'b0) else begin
			errors++;
			$display("** Error at %0t: row %0d out_valid = %b after reset, expected 0",
				$time, row, out_valid);
		end
		assert (halted === 1'b0) else begin
			errors++;
			$display("** Error at %0t: row %0d halted = %b after reset, expected 0",
				$time, row, halted);
		end
		cycles = 0;
		while (halted !== 1'b1 && cycles < HALT_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		assert (halted === 1'b1) else begin
			timeouts++;
			$display("Row %0d never halted within %0d cycles", row, HALT_TIMEOUT);
		end
		repeat (DRAIN_CYCLES) @(negedge clock);  // late pulses would show here
		#1;
		check_outputs(row);
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b0;
		prog_write = 1'b0;
		prog_address = '0;
		prog_data = '0;
		in = '0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		fill_table();
		random_state = next_random(32'd54055);
		input_table[RANDOM_ROW] = random_state[31:16];  // upper bits of the state
		expect_table[RANDOM_ROW][0] = input_table[RANDOM_ROW] + input_table[RANDOM_ROW];
		for (int row = 0; row < ROW_COUNT; row++)
			run_row(row);
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: simple_cpu.f
+incdir+sim
source/cpu_isa_pkg.sv
source/cpu_machine_pkg.sv
source/fetch_link_if.sv
source/memory_link_if.sv
source/fetch_unit.sv
source/register_file.sv
source/decode_unit.sv
source/execute_unit.sv
source/memory_unit.sv
source/simple_cpu.sv
sim/simple_cpu_tb.sv
